// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_dcache -f sources.f -o Vtb_dcache

out=$(./obj_dir/Vtb_dcache 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
else
    exit 1
fi

// File: sources.f
src/mem_op_pkg.sv
src/dcache_pkg.sv
src/dcache_array.sv
src/main_mem_ctrl.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tests/tb_dcache.sv

// File: src/dcache_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_array
    import mem_op_pkg::*;
    import dcache_pkg::*;
(
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic [31:0]         lookup_addr_i,
    input  wire logic                store_en_i,
    input  wire logic [MEM_OP_W-1:0] store_kind_i,
    input  wire logic [31:0]         store_data_i,
    input  wire logic                refill_en_i,
    input  wire logic [LINE_W-1:0]   refill_line_i,
    output logic                     hit_o,
    output logic      [LINE_W-1:0]   hit_line_o,
    output logic                     victim_dirty_o,
    output logic      [LINE_W-1:0]   victim_line_o,
    output logic      [31:0]         victim_addr_o
);

    logic [LINE_W-1:0]      data_q [CACHE_LINES];
    logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid_q;
    logic [CACHE_LINES-1:0] dirty_q;

    dcache_addr_u        req;
    dcache_addr_u        victim;
    logic [INDEX_W-1:0]  idx;
    logic [3:0]          wmask;
    logic [31:0]         wdata_sh;
    logic [LINE_W-1:0]   merged;

    // field view decodes the lookup address
    always_comb begin
        req.raw = lookup_addr_i;
        idx     = req.f.index;
    end

    assign hit_o      = valid_q[idx] && (tag_q[idx] == req.f.tag);
    assign hit_line_o = data_q[idx];

    // victim address rebuilt from the stored tag
    always_comb begin
        victim.f.tag    = tag_q[idx];
        victim.f.index  = idx;
        victim.f.offset = '0;
    end

    assign victim_addr_o  = victim.raw;
    assign victim_dirty_o = valid_q[idx] && dirty_q[idx];
    assign victim_line_o  = data_q[idx];

    // byte lanes within the addressed word
    always_comb begin
        case (store_kind_i)
            MEM_SB: begin
                wmask    = 4'b0001 << req.f.offset[1:0];
                wdata_sh = {4{store_data_i[7:0]}};
            end
            MEM_SH: begin
                wmask    = 4'b0011 << req.f.offset[1:0];
                wdata_sh = {2{store_data_i[15:0]}};
            end
            default: begin
                wmask    = 4'b1111;
                wdata_sh = store_data_i;
            end
        endcase
    end

    // merge store bytes into the current line
    always_comb begin
        logic [OFFSET_W-1:0] bpos;
        merged = data_q[idx];
        for (int b = 0; b < LINE_BYTES; b++) begin
            bpos = OFFSET_W'(b);
            if (bpos[3:2] == req.f.offset[3:2] && wmask[bpos[1:0]]) begin
                merged[b*8 +: 8] = wdata_sh[bpos[1:0]*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_en_i) begin
            data_q[idx] <= refill_line_i;
            tag_q[idx]  <= req.f.tag;
        end else if (store_en_i) begin
            data_q[idx] <= merged;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (refill_en_i) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
        end else if (store_en_i) begin
            dirty_q[idx] <= 1'b1;
        end
    end

    a_one_write: assert property (@(posedge clk_i) disable iff (rst_i)
        !(store_en_i && refill_en_i))
        else $error("store and refill in the same cycle");

endmodule

`default_nettype wire

// File: src/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import mem_op_pkg::*;
    import dcache_pkg::*;
(
    input  wire logic                clk_i,
    input  wire logic                rst_i,

    // pipeline side
    input  wire logic                mem_read_i,
    input  wire logic                mem_write_i,
    input  wire logic [MEM_OP_W-1:0] op_kind_i,
    input  wire logic [31:0]         addr_i,
    input  wire logic [31:0]         wdata_i,
    input  wire logic                hold_i,
    output logic      [31:0]         result_o,
    output logic                     result_valid_o,
    output logic                     ready_o,

    // cache array
    input  wire logic                hit_i,
    input  wire logic [LINE_W-1:0]   hit_line_i,
    input  wire logic                victim_dirty_i,
    input  wire logic [LINE_W-1:0]   victim_line_i,
    input  wire logic [31:0]         victim_addr_i,
    output logic                     store_en_o,
    output logic      [MEM_OP_W-1:0] store_kind_o,
    output logic      [31:0]         store_data_o,
    output logic                     refill_en_o,
    output logic      [LINE_W-1:0]   refill_line_o,

    // main memory
    input  wire logic                mem_idle_i,
    input  wire logic                mem_ready_i,
    input  wire logic [LINE_W-1:0]   mem_rline_i,
    output logic                     mem_req_o,
    output logic                     mem_we_o,
    output logic      [31:0]         mem_addr_o,
    output logic      [LINE_W-1:0]   mem_wline_o
);

    dcache_state_e       state_q;
    dcache_state_e       state_d;
    dcache_addr_u        req_addr;
    logic                access;
    logic                miss_start;
    logic                fetch_start;
    logic [31:0]         fetch_addr;
    logic [OFFSET_W-1:0] off;
    logic [31:0]         lword;
    logic [31:0]         lshift;
    logic [31:0]         load_data;
    logic                load_misaligned;
    logic [LINE_W-1:0]   line_q;
    logic                got_line_q;

    assign access = mem_read_i | mem_write_i;

    // raw view gives the line-aligned fetch address and the byte offset
    always_comb begin
        req_addr.raw = addr_i;
        fetch_addr   = {req_addr.raw[31:OFFSET_W], {OFFSET_W{1'b0}}};
        off          = req_addr.raw[OFFSET_W-1:0];
    end

    // load extraction from the hit line
    always_comb begin
        lword  = hit_line_i[{off[3:2], 5'b00000} +: 32];
        lshift = lword >> {off[1:0], 3'b000};
        case (op_kind_i)
            MEM_LB:  load_data = {{24{lshift[7]}}, lshift[7:0]};
            MEM_LH:  load_data = {{16{lshift[15]}}, lshift[15:0]};
            MEM_LBU: load_data = {24'd0, lshift[7:0]};
            MEM_LHU: load_data = {16'd0, lshift[15:0]};
            default: load_data = lword;
        endcase
    end

    always_comb begin
        case (op_kind_i)
            MEM_LH, MEM_LHU: load_misaligned = off[0];
            MEM_LW:          load_misaligned = |off[1:0];
            default:         load_misaligned = 1'b0;
        endcase
    end

    // miss in LOOKUP starts a writeback or a fetch
    assign miss_start  = (state_q == LOOKUP) && !hold_i && access && !hit_i;
    // read follows the cycle after the writeback's ready pulse
    assign fetch_start = (state_q == WRITEBACK) && !hold_i && mem_idle_i && !mem_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (miss_start) begin
                    state_d = victim_dirty_i ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                if (fetch_start) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (!hold_i && (mem_ready_i || got_line_q)) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (!hold_i) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = LOOKUP;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= LOOKUP;
            got_line_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // keep the fetched line pending while hold is up
            if (state_q == FETCH && mem_ready_i && hold_i) begin
                got_line_q <= 1'b1;
            end else if (state_q != FETCH) begin
                got_line_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == FETCH && mem_ready_i) begin
            line_q <= mem_rline_i;
        end
    end

    // memory requests
    assign mem_req_o   = miss_start | fetch_start;
    assign mem_we_o    = (state_q == LOOKUP) && victim_dirty_i;
    assign mem_addr_o  = mem_we_o ? victim_addr_i : fetch_addr;
    assign mem_wline_o = victim_line_i;

    // array writes
    assign store_en_o    = (state_q == LOOKUP) && !hold_i && mem_write_i && hit_i;
    assign store_kind_o  = op_kind_i;
    assign store_data_o  = wdata_i;
    assign refill_en_o   = (state_q == REFILL) && !hold_i;
    assign refill_line_o = line_q;

    // pipeline results
    assign result_o       = access ? load_data : addr_i;
    assign result_valid_o = !hold_i && (!access || (state_q == LOOKUP && hit_i));
    assign ready_o        = (state_q == LOOKUP) && !(access && !hit_i);

    a_rw_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mem_read_i && mem_write_i))
        else $error("read and write requested together");

    a_req_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_o |-> mem_idle_i)
        else $error("memory request while main memory busy");

    a_load_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_read_i |-> !load_misaligned)
        else $error("misaligned load address");

endmodule

`default_nettype wire

// File: src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // line geometry
    localparam int LINE_BYTES  = 16;
    localparam int LINE_W      = 128;
    localparam int INDEX_W     = 4;
    localparam int OFFSET_W    = 4;
    localparam int TAG_W       = 24;
    localparam int CACHE_LINES = 1 << INDEX_W;

    // backing store, line addresses wrap modulo MEM_LINES
    localparam int MEM_LINES   = 256;
    localparam int MEM_IDX_W   = 8;
    localparam int MEM_LATENCY = 4;
    localparam int MEM_CNT_W   = 2;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } dcache_addr_fields_t;

    // one address word, seen either raw or split into fields
    typedef union packed {
        logic [31:0]         raw;
        dcache_addr_fields_t f;
    } dcache_addr_u;

    typedef enum logic [1:0] {
        LOOKUP    = 2'b00,
        WRITEBACK = 2'b01,
        FETCH     = 2'b10,
        REFILL    = 2'b11
    } dcache_state_e;

endpackage

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import mem_op_pkg::*;
    import dcache_pkg::*;
(
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic                mem_read_i,
    input  wire logic                mem_write_i,
    input  wire logic [MEM_OP_W-1:0] op_kind_i,
    input  wire logic [31:0]         addr_i,
    input  wire logic [31:0]         wdata_i,
    input  wire logic                hold_i,
    output logic      [31:0]         result_o,
    output logic                     result_valid_o,
    output logic                     ready_o
);

    // controller <-> array
    logic                store_en;
    logic [MEM_OP_W-1:0] store_kind;
    logic [31:0]         store_data;
    logic                refill_en;
    logic [LINE_W-1:0]   refill_line;
    logic                hit;
    logic [LINE_W-1:0]   hit_line;
    logic                victim_dirty;
    logic [LINE_W-1:0]   victim_line;
    logic [31:0]         victim_addr;

    // controller <-> main memory
    logic                mem_req;
    logic                mem_we;
    logic [31:0]         mem_addr;
    logic [LINE_W-1:0]   mem_wline;
    logic                mem_idle;
    logic                mem_ready;
    logic [LINE_W-1:0]   mem_rline;

    dcache_ctrl ctrl_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .op_kind_i      (op_kind_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .hold_i         (hold_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .ready_o        (ready_o),
        .hit_i          (hit),
        .hit_line_i     (hit_line),
        .victim_dirty_i (victim_dirty),
        .victim_line_i  (victim_line),
        .victim_addr_i  (victim_addr),
        .store_en_o     (store_en),
        .store_kind_o   (store_kind),
        .store_data_o   (store_data),
        .refill_en_o    (refill_en),
        .refill_line_o  (refill_line),
        .mem_idle_i     (mem_idle),
        .mem_ready_i    (mem_ready),
        .mem_rline_i    (mem_rline),
        .mem_req_o      (mem_req),
        .mem_we_o       (mem_we),
        .mem_addr_o     (mem_addr),
        .mem_wline_o    (mem_wline)
    );

    // the array looks up the request address directly
    dcache_array array_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_addr_i  (addr_i),
        .store_en_i     (store_en),
        .store_kind_i   (store_kind),
        .store_data_i   (store_data),
        .refill_en_i    (refill_en),
        .refill_line_i  (refill_line),
        .hit_o          (hit),
        .hit_line_o     (hit_line),
        .victim_dirty_o (victim_dirty),
        .victim_line_o  (victim_line),
        .victim_addr_o  (victim_addr)
    );

    main_mem_ctrl mem_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .mem_req_i   (mem_req),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wline_i (mem_wline),
        .mem_idle_o  (mem_idle),
        .mem_ready_o (mem_ready),
        .mem_rline_o (mem_rline)
    );

endmodule

`default_nettype wire

// File: src/main_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module main_mem_ctrl
    import dcache_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic              mem_req_i,
    input  wire logic              mem_we_i,
    input  wire logic [31:0]       mem_addr_i,
    input  wire logic [LINE_W-1:0] mem_wline_i,
    output logic                   mem_idle_o,
    output logic                   mem_ready_o,
    output logic      [LINE_W-1:0] mem_rline_o
);

    logic [LINE_W-1:0]    mem_q [MEM_LINES];
    logic                 busy_q;
    logic [MEM_CNT_W-1:0] cnt_q;
    logic                 ready_q;
    logic [MEM_IDX_W-1:0] idx_q;
    logic                 we_q;
    logic [LINE_W-1:0]    wline_q;
    logic [LINE_W-1:0]    rline_q;
    logic                 start;
    logic                 done;

    assign start = mem_req_i && !busy_q;
    // last cycle of the countdown performs the access
    assign done  = busy_q && (cnt_q == MEM_CNT_W'(1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= done;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= MEM_CNT_W'(MEM_LATENCY - 1);
            end else if (done) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // request payload, address wraps modulo MEM_LINES
    always_ff @(posedge clk_i) begin
        if (start) begin
            idx_q   <= mem_addr_i[OFFSET_W +: MEM_IDX_W];
            we_q    <= mem_we_i;
            wline_q <= mem_wline_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < MEM_LINES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (done) begin
            rline_q <= mem_q[idx_q];
            if (we_q) begin
                mem_q[idx_q] <= wline_q;
            end
        end
    end

    assign mem_idle_o  = !busy_q;
    assign mem_ready_o = ready_q;
    assign mem_rline_o = rline_q;

    a_no_req_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        busy_q |-> !mem_req_i)
        else $error("request while main memory busy");

endmodule

`default_nettype wire

// File: src/mem_op_pkg.sv
`default_nettype none

// load/store kind codes carried alongside mem_read_i / mem_write_i
// loads and stores share one field, told apart by the read/write strobes
package mem_op_pkg;

    localparam int MEM_OP_W = 3;

    // load kinds, funct3 style
    localparam logic [MEM_OP_W-1:0] MEM_LB  = 3'b000;
    localparam logic [MEM_OP_W-1:0] MEM_LH  = 3'b001;
    localparam logic [MEM_OP_W-1:0] MEM_LW  = 3'b010;
    localparam logic [MEM_OP_W-1:0] MEM_LBU = 3'b100;
    localparam logic [MEM_OP_W-1:0] MEM_LHU = 3'b101;

    // store kinds
    localparam logic [MEM_OP_W-1:0] MEM_SB  = 3'b000;
    localparam logic [MEM_OP_W-1:0] MEM_SH  = 3'b001;
    localparam logic [MEM_OP_W-1:0] MEM_SW  = 3'b010;

endpackage

`default_nettype wire

// File: tests/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import mem_op_pkg::*;
();

    localparam int TIMEOUT = 50;

    logic                clk_i;
    logic                rst_i;
    logic                mem_read_i;
    logic                mem_write_i;
    logic [MEM_OP_W-1:0] op_kind_i;
    logic [31:0]         addr_i;
    logic [31:0]         wdata_i;
    logic                hold_i;
    logic [31:0]         result_o;
    logic                result_valid_o;
    logic                ready_o;

    // byte-level reference memory that wraps at 4 KiB like main memory
    logic [7:0] ref_mem [4096];
    integer     seed;

    dcache_top dut_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .op_kind_i      (op_kind_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .hold_i         (hold_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .ready_o        (ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at time %0t: %s: got %h, expected %h", $time, what, actual,
                     expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] predict_load(input logic [MEM_OP_W-1:0] kind,
                                                 input logic [31:0] addr);
        logic [11:0] a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[11:0];
        b = ref_mem[a];
        h = {ref_mem[a + 12'd1], ref_mem[a]};
        case (kind)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'd0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'd0, h};
            default: return {ref_mem[a + 12'd3], ref_mem[a + 12'd2], h};
        endcase
    endfunction

    task automatic update_ref(input logic [MEM_OP_W-1:0] kind, input logic [31:0] addr,
                              input logic [31:0] data);
        logic [11:0] a;
        a = addr[11:0];
        ref_mem[a] = data[7:0];
        if (kind == MEM_SH || kind == MEM_SW) begin
            ref_mem[a + 12'd1] = data[15:8];
        end
        if (kind == MEM_SW) begin
            ref_mem[a + 12'd2] = data[23:16];
            ref_mem[a + 12'd3] = data[31:24];
        end
    endtask

    // waits for result_valid_o, lets the access commit, then drops the request
    task automatic finish_access(output logic [31:0] result, output logic stalled);
        int   cycles;
        logic got;
        cycles  = 0;
        got     = 1'b0;
        stalled = 1'b0;
        result  = '0;
        while (!got) begin
            #1;
            if (!ready_o) begin
                stalled = 1'b1;
            end
            if (result_valid_o) begin
                result = result_o;
                got    = 1'b1;
            end else begin
                cycles++;
                if (cycles > TIMEOUT) begin
                    $display("timeout: no result_valid_o within %0d cycles", TIMEOUT);
                    $display("STATUS: FAIL");
                    $fatal(1, "access timed out");
                end else begin
                    @(negedge clk_i);
                end
            end
        end
        @(posedge clk_i);
        @(negedge clk_i);
        mem_read_i  = 1'b0;
        mem_write_i = 1'b0;
    endtask

    task automatic do_access(input logic rd, input logic wr, input logic [MEM_OP_W-1:0] kind,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             output logic [31:0] result, output logic stalled);
        @(negedge clk_i);
        mem_read_i  = rd;
        mem_write_i = wr;
        op_kind_i   = kind;
        addr_i      = addr;
        wdata_i     = wdata;
        finish_access(result, stalled);
    endtask

    task automatic store_and_model(input logic [MEM_OP_W-1:0] kind, input logic [31:0] addr,
                                   input logic [31:0] data, output logic stalled);
        logic [31:0] res;
        do_access(1'b0, 1'b1, kind, addr, data, res, stalled);
        update_ref(kind, addr, data);
    endtask

    task automatic load_and_check(input logic [MEM_OP_W-1:0] kind, input logic [31:0] addr,
                                  output logic stalled);
        logic [31:0] res;
        do_access(1'b1, 1'b0, kind, addr, 32'd0, res, stalled);
        check_value(res, predict_load(kind, addr), $sformatf("load kind %0d at %h", kind, addr));
    endtask

    task automatic reset_and_passthrough();
        logic [31:0] res;
        logic        st;
        // hold is still high here, so no result is offered
        check_value(32'(ready_o), 32'd1, "ready_o after reset");
        check_value(32'(result_valid_o), 32'd0, "result_valid_o after reset");
        @(negedge clk_i);
        hold_i = 1'b0;
        do_access(1'b0, 1'b0, MEM_LW, 32'h1234_5678, 32'd0, res, st);
        check_value(res, 32'h1234_5678, "pass-through result");
        check_value(32'(st), 32'd0, "pass-through stall");
    endtask

    task automatic word_store_then_load();
        logic st;
        store_and_model(MEM_SW, 32'h0000_00a4, $random(seed), st);
        check_value(32'(st), 32'd1, "first store should miss");
        load_and_check(MEM_LW, 32'h0000_00a4, st);
        check_value(32'(st), 32'd0, "load after refill should hit");
        store_and_model(MEM_SW, 32'h0000_00a8, $random(seed), st);
        check_value(32'(st), 32'd0, "store to cached line should hit");
        load_and_check(MEM_LW, 32'h0000_00a8, st);
        check_value(32'(st), 32'd0, "second load from cached line should hit");
    endtask

    task automatic byte_half_offsets();
        logic        st;
        logic [31:0] base;
        base = 32'h0000_0200;
        for (int off = 0; off < 16; off++) begin
            store_and_model(MEM_SB, base + 32'(off), $random(seed), st);
        end
        for (int off = 0; off < 16; off++) begin
            load_and_check(MEM_LB, base + 32'(off), st);
            load_and_check(MEM_LBU, base + 32'(off), st);
        end
        for (int off = 0; off < 16; off += 4) begin
            load_and_check(MEM_LW, base + 32'(off), st);
        end
        for (int off = 0; off < 16; off += 2) begin
            store_and_model(MEM_SH, base + 32'(off), $random(seed), st);
            load_and_check(MEM_LH, base + 32'(off), st);
            load_and_check(MEM_LHU, base + 32'(off), st);
        end
        for (int off = 0; off < 16; off += 4) begin
            load_and_check(MEM_LW, base + 32'(off), st);
        end
    endtask

    task automatic conflict_eviction();
        logic        st;
        logic [31:0] res;
        // same index 4 with different tags
        store_and_model(MEM_SW, 32'h0000_0048, 32'hcafe_f00d, st);
        load_and_check(MEM_LW, 32'h0000_0348, st);
        check_value(32'(st), 32'd1, "conflicting line should miss");
        load_and_check(MEM_LW, 32'h0000_0048, st);
        check_value(32'(st), 32'd1, "evicted line should miss");
        do_access(1'b1, 1'b0, MEM_LW, 32'h0000_07f0, 32'd0, res, st);
        check_value(res, 32'd0, "untouched line reads zero");
    endtask

    task automatic hold_during_miss();
        logic        st;
        logic [31:0] res;
        // put data for 0x690 into main memory, then evict it
        store_and_model(MEM_SW, 32'h0000_0690, 32'h5a5a_1234, st);
        load_and_check(MEM_LW, 32'h0000_0790, st);
        @(negedge clk_i);
        mem_read_i = 1'b1;
        op_kind_i  = MEM_LW;
        addr_i     = 32'h0000_0690;
        #1;
        check_value(32'(result_valid_o), 32'd0, "miss completed at once");
        check_value(32'(ready_o), 32'd0, "ready_o during miss");
        @(negedge clk_i);
        hold_i = 1'b1;
        // long enough for the fetch to finish under hold
        repeat (10) begin
            #1;
            check_value(32'(result_valid_o), 32'd0, "result_valid_o under hold");
            @(negedge clk_i);
        end
        hold_i = 1'b0;
        finish_access(res, st);
        check_value(res, predict_load(MEM_LW, 32'h0000_0690), "load after hold");
    endtask

    task automatic random_sequence();
        logic [31:0]         r;
        logic [31:0]         addr;
        logic [3:0]          off;
        logic [MEM_OP_W-1:0] kind;
        logic                is_store;
        logic                st;
        for (int n = 0; n < 200; n++) begin
            r        = $random(seed);
            is_store = 1'b0;
            case (r[2:0])
                3'd0: kind = MEM_LB;
                3'd1: kind = MEM_LH;
                3'd2: kind = MEM_LW;
                3'd3: kind = MEM_LBU;
                3'd4: kind = MEM_LHU;
                3'd5: begin
                    kind     = MEM_SB;
                    is_store = 1'b1;
                end
                3'd6: begin
                    kind     = MEM_SH;
                    is_store = 1'b1;
                end
                default: begin
                    kind     = MEM_SW;
                    is_store = 1'b1;
                end
            endcase
            off = r[11:8];
            if (kind == MEM_LW || (is_store && kind == MEM_SW)) begin
                off[1:0] = 2'b00;
            end else if (kind == MEM_LH || kind == MEM_LHU || (is_store && kind == MEM_SH)) begin
                off[0] = 1'b0;
            end
            addr = {22'd0, r[21:16], off};
            if (is_store) begin
                store_and_model(kind, addr, $random(seed), st);
            end else begin
                load_and_check(kind, addr, st);
            end
        end
    endtask

    initial begin
        seed        = 32'h6c6139e6;
        rst_i       = 1'b1;
        hold_i      = 1'b1;
        mem_read_i  = 1'b0;
        mem_write_i = 1'b0;
        op_kind_i   = MEM_LW;
        addr_i      = 32'd0;
        wdata_i     = 32'd0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = 8'd0;
        end
        repeat (4) @(negedge clk_i);
        rst_i = 1'b0;
        #1;
        reset_and_passthrough();
        word_store_then_load();
        byte_half_offsets();
        conflict_eviction();
        hold_during_miss();
        random_sequence();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
